// File: list.f
llc_data_pkg.sv
llc_data_sram.sv
llc_data_way.sv
llc_unit_arbiter.sv
llc_data_ways.sv
llc_data_top.sv
tb_clk_gen.sv
tb_llc_data.sv

// File: llc_data_pkg.sv
//----------------------------------------------------------
// geometry, unit names and request/response structs for the
// llc data storage stage, imported by every design module
//----------------------------------------------------------
package llc_data_pkg;

  //----------------------------------------------------------
  // cache geometry
  //----------------------------------------------------------
  // units sharing the data ways
  localparam int unsigned NumUnits          = 4;
  // set associativity
  localparam int unsigned NumWays           = 4;
  // line address bits, 16 lines per way
  localparam int unsigned IndexLength       = 4;
  // block offset bits, 4 blocks per line
  localparam int unsigned BlockOffsetLength = 2;
  // one block is one data word of a line
  localparam int unsigned BlockWidth        = 64;
  localparam int unsigned StrbWidth         = BlockWidth / 8;
  // reads that may be outstanding in the way container
  localparam int unsigned ReadFifoDepth     = 4;

  // derived sizes
  localparam int unsigned NumLines      = 1 << IndexLength;
  localparam int unsigned NumBlocks     = 1 << BlockOffsetLength;
  localparam int unsigned SramAddrWidth = IndexLength + BlockOffsetLength;
  localparam int unsigned UnitIdxWidth  = $clog2(NumUnits);
  localparam int unsigned WayIdxWidth   = $clog2(NumWays);
  localparam int unsigned FifoPtrWidth  = $clog2(ReadFifoDepth);
  localparam int unsigned FifoCntWidth  = $clog2(ReadFifoDepth + 1);

  //----------------------------------------------------------
  // types
  //----------------------------------------------------------
  // value equals the unit's port number
  typedef enum logic [UnitIdxWidth-1:0] {
    EVICT_UNIT  = 2'd0,
    REFILL_UNIT = 2'd1,
    WRITE_UNIT  = 2'd2,
    READ_UNIT   = 2'd3
  } cache_unit_e;

  typedef logic [BlockWidth-1:0] blk_data_t;
  typedef logic [StrbWidth-1:0]  blk_strb_t;

  // request as issued by a unit, way_ind is one-hot
  typedef struct packed {
    logic [NumWays-1:0]           way_ind;
    logic [IndexLength-1:0]       line_addr;
    logic [BlockOffsetLength-1:0] blk_offset;
    logic                         we;
    blk_data_t                    data;
    blk_strb_t                    strb;
  } unit_req_t;

  // request inside the container, tagged with the issuing unit
  typedef struct packed {
    cache_unit_e                  cache_unit;
    logic [NumWays-1:0]           way_ind;
    logic [IndexLength-1:0]       line_addr;
    logic [BlockOffsetLength-1:0] blk_offset;
    logic                         we;
    blk_data_t                    data;
    blk_strb_t                    strb;
  } way_req_t;

  // read data of a way plus its destination unit
  typedef struct packed {
    cache_unit_e cache_unit;
    blk_data_t   data;
  } way_rsp_t;

endpackage

// File: llc_data_sram.sv
//----------------------------------------------------------
// single-port data macro model with byte enables
// read data is registered and appears one cycle after req_i
//----------------------------------------------------------
module llc_data_sram
  import llc_data_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [SramAddrWidth-1:0] addr_i,
  input  blk_data_t                wdata_i,
  input  blk_strb_t                be_i,
  output blk_data_t                rdata_o
);

  // one word per block of every line
  blk_data_t mem_q [NumLines * NumBlocks];
  // output register, holds until the next read
  blk_data_t rdata_q;

  // byte-masked write
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < StrbWidth; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read port, one cycle latency
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: llc_data_stimulus.txt
# columns (hex): phase unit way line offset we strb data expected
# phase 0 fairness writes, 1 single accesses, 2 reads under back-pressure
0 0 0 1 0 1 ff a000000000000001 0
0 0 1 1 0 1 ff a000000000000002 0
0 1 2 1 0 1 ff b000000000000001 0
0 1 3 1 0 1 ff b000000000000002 0
0 2 0 2 1 1 ff c000000000000001 0
0 2 1 2 1 1 ff c000000000000002 0
0 3 2 2 1 1 ff d000000000000001 0
0 3 3 2 1 1 ff d000000000000002 0
1 0 0 5 3 1 ff 0123456789abcdef 0
1 1 0 5 3 0 00 0 0123456789abcdef
1 2 3 2 1 0 00 0 d000000000000002
1 3 0 1 0 0 00 0 a000000000000001
1 0 0 7 2 1 ff 1111111111111111 0
1 1 1 7 2 1 ff 2222222222222222 0
1 2 2 7 2 1 ff 3333333333333333 0
1 3 0 7 2 1 0f aaaaaaaaaaaaaaaa 0
1 0 1 7 2 1 f0 bbbbbbbbbbbbbbbb 0
1 1 2 7 2 1 5a cccccccccccccccc 0
1 2 0 7 2 0 00 0 11111111aaaaaaaa
1 3 1 7 2 0 00 0 bbbbbbbb22222222
1 0 2 7 2 0 00 0 33cc33cccc33cc33
2 0 3 1 0 0 00 0 b000000000000002
2 0 0 7 2 0 00 0 11111111aaaaaaaa
2 1 1 2 1 0 00 0 c000000000000002
2 1 0 5 3 0 00 0 0123456789abcdef
2 2 2 7 2 0 00 0 33cc33cccc33cc33
2 2 0 1 0 0 00 0 a000000000000001
2 3 1 7 2 0 00 0 bbbbbbbb22222222
2 3 2 2 1 0 00 0 d000000000000001

// File: llc_data_top.sv
//----------------------------------------------------------
// data storage stage top, four unit ports share the ways
// through a round-robin arbiter, responses return per unit
//----------------------------------------------------------
module llc_data_top
  import llc_data_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  // unit request ports, indexed by cache_unit_e
  input  unit_req_t           req_i [NumUnits],
  input  logic [NumUnits-1:0] req_valid_i,
  output logic [NumUnits-1:0] req_ready_o,
  // unit response ports
  output blk_data_t           rsp_data_o [NumUnits],
  output logic [NumUnits-1:0] rsp_valid_o,
  input  logic [NumUnits-1:0] rsp_ready_i
);

  // granted request, tagged with its unit
  way_req_t arb_req;
  logic     arb_valid;
  logic     arb_ready;

  //----------------------------------------------------------
  // unit arbitration
  //----------------------------------------------------------
  llc_unit_arbiter u_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .arb_o       (arb_req),
    .arb_valid_o (arb_valid),
    .arb_ready_i (arb_ready)
  );

  //----------------------------------------------------------
  // data ways
  //----------------------------------------------------------
  // read ordering and response routing live in here
  llc_data_ways u_ways (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .inp_i       (arb_req),
    .inp_valid_i (arb_valid),
    .inp_ready_o (arb_ready),
    .rsp_data_o  (rsp_data_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

endmodule

// File: llc_data_way.sv
//----------------------------------------------------------
// one cache way, turns requests into data macro accesses
// read data is held on out_o until the container takes it
// writes give no output
//----------------------------------------------------------
module llc_data_way
  import llc_data_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // request from the container
  input  way_req_t inp_i,
  input  logic     inp_valid_i,
  output logic     inp_ready_o,
  // read response towards the container
  output way_rsp_t out_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  // macro side
  logic [SramAddrWidth-1:0] ram_addr;
  logic                     ram_req;
  blk_data_t                ram_rdata;

  // read bookkeeping
  logic        out_valid_q;
  cache_unit_e unit_q;

  // line address in the upper bits, block offset below
  assign ram_addr = {inp_i.line_addr, inp_i.blk_offset};

  //----------------------------------------------------------
  // control
  //----------------------------------------------------------
  // free when nothing is held, or the held read leaves this cycle
  // this keeps the macro busy on back-to-back reads
  assign inp_ready_o = ~out_valid_q | out_ready_i;
  // every accepted request goes to the macro at once
  assign ram_req     = inp_valid_i & inp_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      unit_q      <= EVICT_UNIT;
    end else if (ram_req) begin
      // read data shows up after this edge
      out_valid_q <= ~inp_i.we;
      if (!inp_i.we) begin
        unit_q <= inp_i.cache_unit;
      end
    end else if (out_ready_i) begin
      // held read consumed, nothing new
      out_valid_q <= 1'b0;
    end
  end

  //----------------------------------------------------------
  // data macro
  //----------------------------------------------------------
  llc_data_sram u_data_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (ram_req),
    .we_i    (inp_i.we),
    .addr_i  (ram_addr),
    .wdata_i (inp_i.data),
    .be_i    (inp_i.strb),
    .rdata_o (ram_rdata)
  );

  // sram output register holds the word while out_valid_o is up
  assign out_o.cache_unit = unit_q;
  assign out_o.data       = ram_rdata;
  assign out_valid_o      = out_valid_q;

endmodule

// File: llc_data_ways.sv
//----------------------------------------------------------
// container of all data ways, steers requests by way_ind
// and returns read data in acceptance order through a FIFO
// of way numbers, each response goes to its issuing unit
//----------------------------------------------------------
module llc_data_ways
  import llc_data_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  // arbitrated request
  input  way_req_t            inp_i,
  input  logic                inp_valid_i,
  output logic                inp_ready_o,
  // per unit read responses
  output blk_data_t           rsp_data_o [NumUnits],
  output logic [NumUnits-1:0] rsp_valid_o,
  input  logic [NumUnits-1:0] rsp_ready_i
);

  // per way handshakes
  logic [NumWays-1:0] way_inp_valid;
  logic [NumWays-1:0] way_inp_ready;
  logic [NumWays-1:0] way_out_valid;
  logic [NumWays-1:0] way_out_ready;
  way_rsp_t           way_out [NumWays];

  // read-order FIFO of way numbers
  logic [WayIdxWidth-1:0]  fifo_q [ReadFifoDepth];
  logic [FifoPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [FifoCntWidth-1:0] cnt_q;
  logic                    fifo_empty, fifo_full;
  logic                    fifo_push, fifo_pop, fifo_room;

  // request and head side
  logic [WayIdxWidth-1:0] inp_way_idx;
  logic                   inp_room;
  logic [WayIdxWidth-1:0] head_way;
  way_rsp_t               head_rsp;
  logic                   head_valid, head_ready;

  function automatic logic [FifoPtrWidth-1:0] ptr_inc(input logic [FifoPtrWidth-1:0] ptr);
    ptr_inc = (ptr == FifoPtrWidth'(ReadFifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // one-hot way index to way number
  always_comb begin
    inp_way_idx = '0;
    for (int unsigned w = 0; w < NumWays; w++) begin
      if (inp_i.way_ind[w]) begin
        inp_way_idx = WayIdxWidth'(w);
      end
    end
  end

  //----------------------------------------------------------
  // response side
  //----------------------------------------------------------
  assign fifo_empty = (cnt_q == '0);
  assign fifo_full  = (cnt_q == FifoCntWidth'(ReadFifoDepth));
  // oldest outstanding read decides which way may answer
  assign head_way   = fifo_q[rd_ptr_q];
  assign head_rsp   = way_out[head_way];
  assign head_valid = ~fifo_empty & way_out_valid[head_way];
  assign head_ready = rsp_ready_i[head_rsp.cache_unit];
  assign fifo_pop   = head_valid & head_ready;

  // data is broadcast, valid picks the unit
  for (genvar u = 0; u < NumUnits; u++) begin : gen_rsp
    assign rsp_valid_o[u] = head_valid & (head_rsp.cache_unit == UnitIdxWidth'(u));
    assign rsp_data_o[u]  = head_rsp.data;
  end

  //----------------------------------------------------------
  // request side
  //----------------------------------------------------------
  // a slot frees up in the same cycle when the head leaves
  assign fifo_room     = ~fifo_full | fifo_pop;
  // writes never need a FIFO slot
  assign inp_room      = inp_i.we | fifo_room;
  assign way_inp_valid = inp_i.way_ind & {NumWays{inp_valid_i & inp_room}};
  assign inp_ready_o   = |(inp_i.way_ind & way_inp_ready) & inp_room;
  assign fifo_push     = inp_valid_i & inp_ready_o & ~inp_i.we;

  // FIFO storage
  always_ff @(posedge clk_i) begin
    if (fifo_push) begin
      fifo_q[wr_ptr_q] <= inp_way_idx;
    end
  end

  // FIFO pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (fifo_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (fifo_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({fifo_push, fifo_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  //----------------------------------------------------------
  // ways
  //----------------------------------------------------------
  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    // only the head way sees its unit's ready
    assign way_out_ready[w] = head_valid & head_ready & (head_way == WayIdxWidth'(w));

    llc_data_way u_way (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .inp_i       (inp_i),
      .inp_valid_i (way_inp_valid[w]),
      .inp_ready_o (way_inp_ready[w]),
      .out_o       (way_out[w]),
      .out_valid_o (way_out_valid[w]),
      .out_ready_i (way_out_ready[w])
    );
  end

endmodule

// File: llc_unit_arbiter.sv
//----------------------------------------------------------
// round-robin arbiter over the four cache unit ports
// grant is combinational, pointer moves past the winner
//----------------------------------------------------------
module llc_unit_arbiter
  import llc_data_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  // unit request ports
  input  unit_req_t           req_i [NumUnits],
  input  logic [NumUnits-1:0] req_valid_i,
  output logic [NumUnits-1:0] req_ready_o,
  // granted request towards the way container
  output way_req_t            arb_o,
  output logic                arb_valid_o,
  input  logic                arb_ready_i
);

  // priority pointer, first unit to look at
  logic [UnitIdxWidth-1:0] rr_q;
  logic [UnitIdxWidth-1:0] gnt_idx;
  logic                    gnt_found;
  unit_req_t               gnt_req;

  // first valid unit at or after the pointer, wraps around
  always_comb begin : gnt_search
    logic [UnitIdxWidth-1:0] idx;
    gnt_idx   = rr_q;
    gnt_found = 1'b0;
    for (int unsigned i = 0; i < NumUnits; i++) begin
      idx = rr_q + UnitIdxWidth'(i);
      if (!gnt_found && req_valid_i[idx]) begin
        gnt_found = 1'b1;
        gnt_idx   = idx;
      end
    end
  end

  // forward the winner, tagged with its port number
  assign gnt_req          = req_i[gnt_idx];
  assign arb_valid_o      = gnt_found;
  assign arb_o.cache_unit = cache_unit_e'(gnt_idx);
  assign arb_o.way_ind    = gnt_req.way_ind;
  assign arb_o.line_addr  = gnt_req.line_addr;
  assign arb_o.blk_offset = gnt_req.blk_offset;
  assign arb_o.we         = gnt_req.we;
  assign arb_o.data       = gnt_req.data;
  assign arb_o.strb       = gnt_req.strb;

  // ready only back to the granted port
  always_comb begin
    req_ready_o          = '0;
    req_ready_o[gnt_idx] = gnt_found & arb_ready_i;
  end

  // advance one past the winner on each transfer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (arb_valid_o && arb_ready_i) begin
      rr_q <= gnt_idx + 1'b1;
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# builds the llc data stage testbench with Verilator and runs it
# exit status is non-zero when the build, the run or the checks fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_llc_data -o tb_llc_data_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_llc_data_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
  echo "checks failed, see sim.log"
  exit 1
fi

echo "checks passed"
exit 0

// File: tb_clk_gen.sv
//----------------------------------------------------------
// testbench clock and reset, period of 100 time units
// reset is held low for the first two rising edges
//----------------------------------------------------------
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

  always #50 clk_o = ~clk_o;

endmodule

// File: tb_llc_data.sv
//----------------------------------------------------------
// testbench for the llc data storage stage
// replays the accesses of llc_data_stimulus.txt on the four
// unit ports and checks routing, order and data of every read
//----------------------------------------------------------
module tb_llc_data
  import llc_data_pkg::*;
();

  localparam int MaxEntries     = 64;
  localparam int CyclesPerEntry = 40;

  logic                clk;
  logic                rst_n;
  unit_req_t           req [NumUnits];
  logic [NumUnits-1:0] req_valid;
  logic [NumUnits-1:0] req_ready;
  blk_data_t           rsp_data [NumUnits];
  logic [NumUnits-1:0] rsp_valid;
  logic [NumUnits-1:0] rsp_ready;

  // stimulus table with one entry per data line of the file
  int                           e_phase [MaxEntries];
  int                           e_unit  [MaxEntries];
  int                           e_way   [MaxEntries];
  logic [IndexLength-1:0]       e_line  [MaxEntries];
  logic [BlockOffsetLength-1:0] e_off   [MaxEntries];
  logic                         e_we    [MaxEntries];
  blk_strb_t                    e_strb  [MaxEntries];
  blk_data_t                    e_data  [MaxEntries];
  blk_data_t                    e_exp   [MaxEntries];
  int                           n_entries = 0;

  // per unit requests still to issue and reads still to answer
  int issue_list [NumUnits][MaxEntries];
  int issue_head [NumUnits];
  int issue_tail [NumUnits];
  int wait_list  [NumUnits][MaxEntries];
  int wait_head  [NumUnits];
  int wait_tail  [NumUnits];

  logic [31:0] lfsr;
  int          value_errs;
  int          other_errs;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  llc_data_top u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_data_o  (rsp_data),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready)
  );

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic unit_req_t build_req(input int idx);
    unit_req_t r;
    r                     = '0;
    r.way_ind[e_way[idx]] = 1'b1;
    r.line_addr           = e_line[idx];
    r.blk_offset          = e_off[idx];
    r.we                  = e_we[idx];
    r.data                = e_data[idx];
    r.strb                = e_strb[idx];
    return r;
  endfunction

  task automatic load_stimulus();
    int        fd;
    int        ph, un, wy, ln, of, we, sb;
    blk_data_t wd, xd;
    string     line;
    fd = $fopen("llc_data_stimulus.txt", "r");
    if (fd == 0) begin
      $display("stimulus file llc_data_stimulus.txt could not be opened");
      other_errs++;
    end else begin
      while (!$feof(fd) && n_entries < MaxEntries) begin
        line = "";
        // skip blank lines and # comment lines
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h %h %h %h %h %h %h %h",
                      ph, un, wy, ln, of, we, sb, wd, xd) == 9) begin
            e_phase[n_entries] = ph;
            e_unit[n_entries]  = un % NumUnits;
            e_way[n_entries]   = wy % NumWays;
            e_line[n_entries]  = IndexLength'(ln);
            e_off[n_entries]   = BlockOffsetLength'(of);
            e_we[n_entries]    = (we != 0);
            e_strb[n_entries]  = StrbWidth'(sb);
            e_data[n_entries]  = wd;
            e_exp[n_entries]   = xd;
            n_entries++;
          end else begin
            $display("stimulus line could not be parsed: %s", line);
            other_errs++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic clear_lists();
    for (int u = 0; u < NumUnits; u++) begin
      issue_head[u] = 0;
      issue_tail[u] = 0;
      wait_head[u]  = 0;
      wait_tail[u]  = 0;
    end
  endtask

  task automatic add_issue(input int idx);
    issue_list[e_unit[idx]][issue_tail[e_unit[idx]]] = idx;
    issue_tail[e_unit[idx]]++;
  endtask

  task automatic check_idle(input string where);
    if (rsp_valid !== '0) begin
      $display("FAIL t=%0t rsp_valid_o got %b expected %b (%s)",
               $time, rsp_valid, {NumUnits{1'b0}}, where);
      value_errs++;
    end
  endtask

  //----------------------------------------------------------
  // drive all units from their lists until every read is back
  //----------------------------------------------------------
  task automatic run_batch(input bit rand_ready, input bit check_rr);
    int                  idx;
    int                  acc_seen;
    bit                  busy;
    logic [NumUnits-1:0] rdy;
    acc_seen = 0;
    busy     = 1'b1;
    while (busy) begin
      // hold valid and payload until the transfer
      for (int u = 0; u < NumUnits; u++) begin
        if (issue_head[u] != issue_tail[u]) begin
          req[u]       <= build_req(issue_list[u][issue_head[u]]);
          req_valid[u] <= 1'b1;
        end else begin
          req_valid[u] <= 1'b0;
        end
        lfsr   = rand_ready ? lfsr_step(lfsr) : lfsr;
        rdy[u] = rand_ready ? lfsr[0] : 1'b1;
      end
      rsp_ready <= rdy;
      @(posedge clk);
      // each unit is answered in its own issue order
      for (int u = 0; u < NumUnits; u++) begin
        if (rsp_valid[u] && wait_head[u] == wait_tail[u]) begin
          $display("response on unit %0d at t=%0t with no read of it pending", u, $time);
          other_errs++;
        end else if (rsp_valid[u] && rsp_ready[u]) begin
          idx = wait_list[u][wait_head[u]];
          if (rsp_data[u] !== e_exp[idx]) begin
            $display("FAIL t=%0t rsp_data_o[%0d] got %h expected %h",
                     $time, u, rsp_data[u], e_exp[idx]);
            value_errs++;
          end
          wait_head[u]++;
        end
      end
      // accepted requests rotate from unit 0 after reset
      for (int u = 0; u < NumUnits; u++) begin
        if (req_valid[u] && req_ready[u]) begin
          idx = issue_list[u][issue_head[u]];
          if (check_rr && u != acc_seen % NumUnits) begin
            $display("FAIL t=%0t accepted unit (req_ready_o) got %0d expected %0d",
                     $time, u, acc_seen % NumUnits);
            value_errs++;
          end
          acc_seen++;
          if (!e_we[idx]) begin
            wait_list[u][wait_tail[u]] = idx;
            wait_tail[u]++;
          end
          issue_head[u]++;
        end
      end
      busy = 1'b0;
      for (int u = 0; u < NumUnits; u++) begin
        if (issue_head[u] != issue_tail[u] || wait_head[u] != wait_tail[u]) begin
          busy = 1'b1;
        end
      end
    end
    req_valid <= '0;
    rsp_ready <= '1;
  endtask

  initial begin
    req        <= '{default: '0};
    req_valid  <= '0;
    rsp_ready  <= '1;
    lfsr       = 32'h5dc8_abc9;
    value_errs = 0;
    other_errs = 0;
    load_stimulus();
    // no response may show during reset or the cycle after
    @(negedge clk);
    while (!rst_n) begin
      check_idle("during reset");
      @(negedge clk);
    end
    check_idle("first cycle after reset");
    @(posedge clk);
    if (n_entries == 0) begin
      $display("no usable stimulus lines were found");
      other_errs++;
    end else begin
      // phase 0 checks fairness with all units at once while the pointer is fresh
      clear_lists();
      for (int i = 0; i < n_entries; i++) begin
        if (e_phase[i] == 0) begin
          add_issue(i);
        end
      end
      run_batch(1'b0, 1'b1);
      // phase 1 one access at a time
      for (int i = 0; i < n_entries; i++) begin
        if (e_phase[i] == 1) begin
          clear_lists();
          add_issue(i);
          run_batch(1'b0, 1'b0);
        end
      end
      // phase 2 concurrent reads with random rsp_ready
      clear_lists();
      for (int i = 0; i < n_entries; i++) begin
        if (e_phase[i] == 2) begin
          add_issue(i);
        end
      end
      run_batch(1'b1, 1'b0);
      @(negedge clk);
      check_idle("after the last response");
    end
    $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // watchdog budget scales with the stimulus length
  initial begin
    wait (n_entries > 0);
    repeat (n_entries * CyclesPerEntry) @(posedge clk);
    $display("watchdog expired after %0d cycles, DUT stopped answering",
             n_entries * CyclesPerEntry);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
